// ==== board_shell_config.svh ====
`ifndef BOARD_SHELL_CONFIG_SVH
`define BOARD_SHELL_CONFIG_SVH

////////////////////
// Clocks
////////////////////

// Core clock coming from the board PLL
`define SOC_CLK_HZ 50000000

// Real-time clock seen by the SoC
`define RTC_HZ 1000000

// soc_clk cycles per RTC half period
`define RTC_HALF_PERIOD (`SOC_CLK_HZ / (2 * `RTC_HZ))

////////////////////
// Misc
////////////////////

// Depth of the reset release synchronizer
`define RST_SYNC_STAGES 2

// soc_clk cycles per fan PWM step
`define FAN_PRESCALE 4

`define USB_NUM_PORTS 2

`endif

// ==== board_shell_pkg.sv ====
`include "board_shell_config.svh"

package board_shell_pkg;

  ////////////////////
  // Boot
  ////////////////////

  // Boot source handed to the SoC at reset release
  typedef enum logic [1:0] {
    BOOT_PASSIVE    = 2'b00,
    BOOT_SD         = 2'b01,
    BOOT_I2C_EEPROM = 2'b10,
    BOOT_RESERVED   = 2'b11
  } boot_mode_e;

  ////////////////////
  // Pad structs
  ////////////////////

  // SPI host outputs and their enables
  typedef struct packed {
    logic       sck;
    logic       sck_en;
    logic [1:0] csb;
    logic [1:0] csb_en;
    logic [3:0] sd;
    logic [3:0] sd_en;
  } spi_host_t;

  // I2C host with open-drain style enables
  typedef struct packed {
    logic scl;
    logic scl_en;
    logic sda;
    logic sda_en;
  } i2c_host_t;

  // One bit per port in each field
  typedef struct packed {
    logic [`USB_NUM_PORTS-1:0] dp;
    logic [`USB_NUM_PORTS-1:0] dp_oe;
    logic [`USB_NUM_PORTS-1:0] dm;
    logic [`USB_NUM_PORTS-1:0] dm_oe;
  } usb_host_t;

endpackage

// ==== sys_ctrl.sv ====
`timescale 1ns/1ps

`include "board_shell_config.svh"

module sys_ctrl import board_shell_pkg::*; (
  input  logic       soc_clk,
  input  logic       rst_n,
  input  logic       test_mode_i,
  input  logic       dbg_reset_i,
  input  boot_mode_e boot_mode_i,
  input  logic       dbg_boot_sel_i,
  input  boot_mode_e dbg_boot_mode_i,
  output logic       soc_rst_no,
  output boot_mode_e boot_mode_o
);

  localparam int STAGES = `RST_SYNC_STAGES;

  logic              rst_comb_n;
  logic [STAGES-1:0] sync_q;
  boot_mode_e        boot_sel;
  boot_mode_e        boot_mode_q;

  ////////////////////
  // Reset
  ////////////////////

  // Board reset or debug reset
  assign rst_comb_n = rst_n & ~dbg_reset_i;

  // Asserts at once, releases after STAGES edges
  always_ff @(posedge soc_clk or negedge rst_comb_n) begin
    if (!rst_comb_n) begin
      sync_q <= '0;
    end else begin
      sync_q <= {sync_q[STAGES-2:0], 1'b1};
    end
  end

  // Test mode bypasses the synchronizer
  assign soc_rst_no = test_mode_i ? rst_comb_n : sync_q[STAGES-1];

  ////////////////////
  // Boot mode
  ////////////////////

  assign boot_sel = dbg_boot_sel_i ? dbg_boot_mode_i : boot_mode_i;

  // Tracks the source while the SoC is in reset, frozen afterwards
  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      boot_mode_q <= BOOT_PASSIVE;
    end else if (!soc_rst_no) begin
      boot_mode_q <= boot_sel;
    end
  end

  assign boot_mode_o = boot_mode_q;

  // Boot mode must not move once the SoC runs
  a_boot_mode_held: assert property (
    @(posedge soc_clk) disable iff (!rst_n)
    soc_rst_no && $past(soc_rst_no) |-> $stable(boot_mode_o)
  ) else $error("boot mode changed while SoC out of reset");

endmodule

// ==== rtc_divider.sv ====
`timescale 1ns/1ps

`include "board_shell_config.svh"

module rtc_divider import board_shell_pkg::*; (
  input  logic soc_clk,
  input  logic rst_n,
  output logic rtc_o
);

  localparam int CNT_W = $clog2(`RTC_HALF_PERIOD);
  localparam logic [CNT_W-1:0] CNT_MAX = CNT_W'(`RTC_HALF_PERIOD - 1);

  logic [CNT_W-1:0] cnt_q;
  logic             rtc_q;

  // Half period counter that flips the output on wrap
  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
      rtc_q <= 1'b0;
    end else if (cnt_q == CNT_MAX) begin
      cnt_q <= '0;
      rtc_q <= ~rtc_q;
    end else begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  assign rtc_o = rtc_q;

  a_cnt_range: assert property (
    @(posedge soc_clk) disable iff (!rst_n)
    cnt_q <= CNT_MAX
  ) else $error("RTC counter out of range");

endmodule

// ==== fan_ctrl.sv ====
`timescale 1ns/1ps

`include "board_shell_config.svh"

module fan_ctrl import board_shell_pkg::*; (
  input  logic       soc_clk,
  input  logic       rst_n,
  input  logic [3:0] fan_sw_i,
  output logic       fan_pwm_o
);

  localparam int PRE_W = $clog2(`FAN_PRESCALE);
  localparam logic [PRE_W-1:0] PRE_MAX = PRE_W'(`FAN_PRESCALE - 1);

  logic [PRE_W-1:0] pre_q;
  logic [3:0]       step_q;
  logic [3:0]       duty_q;
  logic             step_tick;
  logic             period_end;

  assign step_tick  = (pre_q == PRE_MAX);
  assign period_end = step_tick && (step_q == 4'hf);

  ////////////////////
  // Counters
  ////////////////////

  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      pre_q  <= '0;
      step_q <= '0;
    end else begin
      pre_q <= step_tick ? '0 : pre_q + 1'b1;
      if (step_tick) begin
        step_q <= step_q + 1'b1;
      end
    end
  end

  // New setting takes effect on the first step of the next period
  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      duty_q <= '0;
    end else if (period_end) begin
      duty_q <= fan_sw_i;
    end
  end

  // High for duty_q steps at the start of the period
  assign fan_pwm_o = (step_q < duty_q);

  a_pwm_off_at_zero: assert property (
    @(posedge soc_clk) disable iff (!rst_n)
    (duty_q == 4'h0) |-> !fan_pwm_o
  ) else $error("fan PWM high with zero setting");

endmodule

// ==== pad_adapter.sv ====
`timescale 1ns/1ps

`include "board_shell_config.svh"

module pad_adapter import board_shell_pkg::*; (
  // SoC side
  input  spi_host_t                 spi_i,
  output logic [3:0]                spi_sd_o,
  input  i2c_host_t                 i2c_i,
  output logic                      i2c_scl_o,
  output logic                      i2c_sda_o,
  input  usb_host_t                 usb_i,
  output logic [`USB_NUM_PORTS-1:0] usb_dp_o,
  output logic [`USB_NUM_PORTS-1:0] usb_dm_o,
  // Board side
  input  logic                      sd_cd_i,
  output logic                      sd_cd_o,
  output logic                      sd_cmd_o,
  output logic                      sd_sclk_o,
  output logic                      sd_reset_o,
  inout  wire  [3:0]                sd_d_io,
  inout  wire                       i2c_scl_io,
  inout  wire                       i2c_sda_io,
  inout  wire  [`USB_NUM_PORTS-1:0] usb_dp_io,
  inout  wire  [`USB_NUM_PORTS-1:0] usb_dm_io
);

  ////////////////////
  // SPI to SD
  ////////////////////

  // Card powered while reset is low
  assign sd_reset_o = 1'b0;

  // Idle high when the host does not drive
  assign sd_sclk_o  = spi_i.sck_en ? spi_i.sck : 1'b1;
  assign sd_cmd_o   = spi_i.sd_en[0] ? spi_i.sd[0] : 1'b1;

  // DAT3 doubles as chip select
  assign sd_d_io[3] = spi_i.csb_en[0] ? spi_i.csb[0] : 1'b1;

  // DAT1 and DAT2 unused in SPI mode
  assign sd_d_io[2:1] = 2'b11;

  // MISO comes in on DAT0
  assign spi_sd_o = {2'b00, sd_d_io[0], 1'b0};

  assign sd_cd_o = sd_cd_i;

  ////////////////////
  // I2C
  ////////////////////

  assign i2c_scl_io = i2c_i.scl_en ? i2c_i.scl : 1'bz;
  assign i2c_sda_io = i2c_i.sda_en ? i2c_i.sda : 1'bz;

  // Read back the pin, whoever drives it
  assign i2c_scl_o = i2c_scl_io;
  assign i2c_sda_o = i2c_sda_io;

  ////////////////////
  // USB
  ////////////////////

  for (genvar p = 0; p < `USB_NUM_PORTS; p++) begin : gen_usb_pad
    assign usb_dp_io[p] = usb_i.dp_oe[p] ? usb_i.dp[p] : 1'bz;
    assign usb_dm_io[p] = usb_i.dm_oe[p] ? usb_i.dm[p] : 1'bz;
    assign usb_dp_o[p]  = usb_dp_io[p];
    assign usb_dm_o[p]  = usb_dm_io[p];
  end

endmodule

// ==== board_shell.sv ====
`timescale 1ns/1ps

`include "board_shell_config.svh"

module board_shell import board_shell_pkg::*; (
  input  logic                      soc_clk,
  input  logic                      rst_n,
  input  logic                      test_mode_i,
  input  logic                      dbg_reset_i,
  input  logic                      dbg_boot_sel_i,
  input  boot_mode_e                boot_mode_i,
  input  boot_mode_e                dbg_boot_mode_i,
  input  logic [3:0]                fan_sw_i,
  // SoC pad signals
  input  spi_host_t                 spi_i,
  input  i2c_host_t                 i2c_i,
  input  usb_host_t                 usb_i,
  // To the SoC
  output logic                      soc_rst_no,
  output boot_mode_e                boot_mode_o,
  output logic                      rtc_o,
  output logic [3:0]                spi_sd_o,
  output logic                      i2c_scl_o,
  output logic                      i2c_sda_o,
  output logic [`USB_NUM_PORTS-1:0] usb_dp_o,
  output logic [`USB_NUM_PORTS-1:0] usb_dm_o,
  // Board pins
  output logic                      fan_pwm_o,
  input  logic                      sd_cd_i,
  output logic                      sd_cd_o,
  output logic                      sd_cmd_o,
  output logic                      sd_sclk_o,
  output logic                      sd_reset_o,
  inout  wire  [3:0]                sd_d_io,
  inout  wire                       i2c_scl_io,
  inout  wire                       i2c_sda_io,
  inout  wire  [`USB_NUM_PORTS-1:0] usb_dp_io,
  inout  wire  [`USB_NUM_PORTS-1:0] usb_dm_io
);

  // Synchronized SoC reset, shared by all clocked blocks
  logic soc_rst_n;

  ////////////////////
  // Reset and boot
  ////////////////////

  sys_ctrl i_sys_ctrl (
    .soc_clk         ( soc_clk         ),
    .rst_n           ( rst_n           ),
    .test_mode_i     ( test_mode_i     ),
    .dbg_reset_i     ( dbg_reset_i     ),
    .boot_mode_i     ( boot_mode_i     ),
    .dbg_boot_sel_i  ( dbg_boot_sel_i  ),
    .dbg_boot_mode_i ( dbg_boot_mode_i ),
    .soc_rst_no      ( soc_rst_n       ),
    .boot_mode_o     ( boot_mode_o     )
  );

  assign soc_rst_no = soc_rst_n;

  ////////////////////
  // RTC and fan
  ////////////////////

  rtc_divider i_rtc_divider (
    .soc_clk ( soc_clk   ),
    .rst_n   ( soc_rst_n ),
    .rtc_o   ( rtc_o     )
  );

  fan_ctrl i_fan_ctrl (
    .soc_clk   ( soc_clk   ),
    .rst_n     ( soc_rst_n ),
    .fan_sw_i  ( fan_sw_i  ),
    .fan_pwm_o ( fan_pwm_o )
  );

  ////////////////////
  // Pads
  ////////////////////

  pad_adapter i_pad_adapter (
    .spi_i      ( spi_i      ),
    .spi_sd_o   ( spi_sd_o   ),
    .i2c_i      ( i2c_i      ),
    .i2c_scl_o  ( i2c_scl_o  ),
    .i2c_sda_o  ( i2c_sda_o  ),
    .usb_i      ( usb_i      ),
    .usb_dp_o   ( usb_dp_o   ),
    .usb_dm_o   ( usb_dm_o   ),
    .sd_cd_i    ( sd_cd_i    ),
    .sd_cd_o    ( sd_cd_o    ),
    .sd_cmd_o   ( sd_cmd_o   ),
    .sd_sclk_o  ( sd_sclk_o  ),
    .sd_reset_o ( sd_reset_o ),
    .sd_d_io    ( sd_d_io    ),
    .i2c_scl_io ( i2c_scl_io ),
    .i2c_sda_io ( i2c_sda_io ),
    .usb_dp_io  ( usb_dp_io  ),
    .usb_dm_io  ( usb_dm_io  )
  );

endmodule

// ==== tb_board_shell.sv ====
`timescale 1ns/1ps

`include "board_shell_config.svh"

module tb_board_shell import board_shell_pkg::*; ();

  localparam int NP         = `USB_NUM_PORTS;
  localparam int FAN_PERIOD = 16 * `FAN_PRESCALE;

  logic soc_clk = 1'b0;
  logic rst_n, test_mode_i, dbg_reset_i, dbg_boot_sel_i;
  boot_mode_e boot_mode_i, dbg_boot_mode_i, boot_mode_o;
  logic [3:0] fan_sw_i, spi_sd_o;
  spi_host_t spi_i;
  i2c_host_t i2c_i;
  usb_host_t usb_i;
  logic soc_rst_no, rtc_o, fan_pwm_o, i2c_scl_o, i2c_sda_o;
  logic [NP-1:0] usb_dp_o, usb_dm_o;
  logic sd_cd_i, sd_cd_o, sd_cmd_o, sd_sclk_o, sd_reset_o;
  wire [3:0] sd_d_io;
  wire i2c_scl_io, i2c_sda_io;
  wire [NP-1:0] usb_dp_io, usb_dm_io;

  // Board-side drivers for released pins
  logic scl_tb_en, scl_tb, sda_tb_en, sda_tb, sd0_en, sd0_drv;
  logic [NP-1:0] dp_tb_en, dp_tb, dm_tb_en, dm_tb;

  logic [31:0] lcg_state = 32'd70;
  int err_cnt = 0;
  int to_cnt = 0;
  int fan_pick = 0;

  board_shell board_shell_i (.*);

  always #2 soc_clk = ~soc_clk;

  ////////////////////
  // Pins
  ////////////////////

  assign i2c_scl_io = (!i2c_i.scl_en && scl_tb_en) ? scl_tb : 1'bz;
  assign i2c_sda_io = (!i2c_i.sda_en && sda_tb_en) ? sda_tb : 1'bz;
  assign sd_d_io[0] = sd0_en ? sd0_drv : 1'bz;
  pullup (i2c_scl_io);
  pullup (i2c_sda_io);
  pullup (sd_d_io[0]);

  for (genvar p = 0; p < NP; p++) begin : gen_usb_tb
    assign usb_dp_io[p] = (!usb_i.dp_oe[p] && dp_tb_en[p]) ? dp_tb[p] : 1'bz;
    assign usb_dm_io[p] = (!usb_i.dm_oe[p] && dm_tb_en[p]) ? dm_tb[p] : 1'bz;
    pullup (usb_dp_io[p]);
    pullup (usb_dm_io[p]);
  end

  ////////////////////
  // Reference model
  ////////////////////

  logic comb_n, exp_rst_n, exp_rtc = 1'b0;
  int clr_cnt = 0;
  int rtc_cnt = 0;
  int fan_cyc = 0;
  int hi_cnt = 0;
  logic [3:0] fan_set = 4'h0;
  boot_mode_e exp_boot = BOOT_PASSIVE;

  assign comb_n = rst_n & ~dbg_reset_i;
  // Release expected on the second edge after both resets clear
  assign exp_rst_n = test_mode_i ? comb_n : (clr_cnt >= `RST_SYNC_STAGES);

  always @(posedge soc_clk or negedge comb_n) begin
    if (!comb_n) begin
      clr_cnt <= 0;
    end else if (clr_cnt < `RST_SYNC_STAGES) begin
      clr_cnt <= clr_cnt + 1;
    end
  end

  always @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      exp_boot <= BOOT_PASSIVE;
    end else if (!exp_rst_n) begin
      exp_boot <= dbg_boot_sel_i ? dbg_boot_mode_i : boot_mode_i;
    end
  end

  always @(posedge soc_clk or negedge exp_rst_n) begin
    if (!exp_rst_n) begin
      rtc_cnt <= 0;
      exp_rtc <= 1'b0;
    end else if (rtc_cnt == `RTC_HALF_PERIOD - 1) begin
      rtc_cnt <= 0;
      exp_rtc <= ~exp_rtc;
    end else begin
      rtc_cnt <= rtc_cnt + 1;
    end
  end

  // Fan period position, captured setting and measured high time
  always @(posedge soc_clk or negedge exp_rst_n) begin
    if (!exp_rst_n) begin
      fan_cyc <= 0;
      fan_set <= 4'h0;
      hi_cnt  <= 0;
    end else if (fan_cyc == FAN_PERIOD - 1) begin
      fan_cyc <= 0;
      fan_set <= fan_sw_i;
      hi_cnt  <= 0;
    end else begin
      fan_cyc <= fan_cyc + 1;
      hi_cnt  <= hi_cnt + fan_pwm_o;
    end
  end

  // Released pin reads the board driver, else the pull-up
  function automatic logic pin_read(logic oe, logic drv, logic tb_en, logic tb_val);
    if (oe) begin
      return drv;
    end
    return tb_en ? tb_val : 1'b1;
  endfunction

  function automatic logic [NP-1:0] port_read(logic [NP-1:0] oe, logic [NP-1:0] drv,
                                              logic [NP-1:0] tb_en, logic [NP-1:0] tb_val);
    return (oe & drv) | (~oe & tb_en & tb_val) | (~oe & ~tb_en);
  endfunction

  task automatic report_error(input string msg);
    err_cnt++;
    $display("** Error %0t ns: %s", $time, msg);
  endtask

  ////////////////////
  // Checks
  ////////////////////

  a_reset: assert property (@(negedge soc_clk) soc_rst_no == exp_rst_n)
    else report_error("soc_rst_no does not match reset rule");
  a_boot: assert property (@(negedge soc_clk) boot_mode_o == exp_boot)
    else report_error("boot_mode_o differs from captured source");
  a_rtc: assert property (@(negedge soc_clk) rtc_o == exp_rtc)
    else report_error("rtc_o toggled at the wrong edge");
  a_fan_level: assert property (@(negedge soc_clk) fan_pwm_o == (fan_cyc < 4 * fan_set))
    else report_error("fan_pwm_o level wrong for captured setting");
  a_fan_high: assert property (@(posedge soc_clk) disable iff (!exp_rst_n)
    (fan_cyc == FAN_PERIOD - 1) |-> (hi_cnt + fan_pwm_o == 4 * fan_set))
    else report_error("fan high time over one period wrong");
  a_sd_clk_cmd: assert property (@(negedge soc_clk)
    sd_sclk_o == (spi_i.sck_en ? spi_i.sck : 1'b1) &&
    sd_cmd_o == (spi_i.sd_en[0] ? spi_i.sd[0] : 1'b1))
    else report_error("SD clock or command mapping wrong");
  a_sd_cs: assert property (@(negedge soc_clk)
    sd_d_io[3] == (spi_i.csb_en[0] ? spi_i.csb[0] : 1'b1))
    else report_error("SD DAT3 chip select mapping wrong");
  a_sd_fixed: assert property (@(negedge soc_clk)
    sd_d_io[2:1] == 2'b11 && sd_reset_o == 1'b0 && sd_cd_o == sd_cd_i)
    else report_error("SD fixed pins or card detect wrong");
  a_spi_in: assert property (@(negedge soc_clk)
    spi_sd_o == {2'b00, pin_read(1'b0, 1'b0, sd0_en, sd0_drv), 1'b0})
    else report_error("spi_sd_o does not reflect DAT0");
  a_i2c: assert property (@(negedge soc_clk)
    i2c_scl_o == pin_read(i2c_i.scl_en, i2c_i.scl, scl_tb_en, scl_tb) &&
    i2c_sda_o == pin_read(i2c_i.sda_en, i2c_i.sda, sda_tb_en, sda_tb))
    else report_error("I2C pin value wrong");
  a_i2c_pad: assert property (@(negedge soc_clk)
    i2c_scl_io == pin_read(i2c_i.scl_en, i2c_i.scl, scl_tb_en, scl_tb) &&
    i2c_sda_io == pin_read(i2c_i.sda_en, i2c_i.sda, sda_tb_en, sda_tb))
    else report_error("I2C pad level wrong");
  a_usb: assert property (@(negedge soc_clk)
    usb_dp_o == port_read(usb_i.dp_oe, usb_i.dp, dp_tb_en, dp_tb) &&
    usb_dm_o == port_read(usb_i.dm_oe, usb_i.dm, dm_tb_en, dm_tb))
    else report_error("USB pin value wrong");
  a_usb_pad: assert property (@(negedge soc_clk)
    usb_dp_io == port_read(usb_i.dp_oe, usb_i.dp, dp_tb_en, dp_tb) &&
    usb_dm_io == port_read(usb_i.dm_oe, usb_i.dm, dm_tb_en, dm_tb))
    else report_error("USB pad level wrong");

  ////////////////////
  // Stimulus
  ////////////////////

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic drive_random();
    logic [31:0] r1, r2, r3;
    r1 = next_rand();
    r2 = next_rand();
    r3 = next_rand();
    spi_i = r1[31:18];
    i2c_i = r1[17:14];
    usb_i = r2[31:24];
    {scl_tb_en, scl_tb, sda_tb_en, sda_tb} = r2[23:20];
    {sd0_en, sd0_drv} = r2[19:18];
    dp_tb_en = r3[8 +: NP];
    dp_tb = r3[12 +: NP];
    dm_tb_en = r3[16 +: NP];
    dm_tb = r3[20 +: NP];
    boot_mode_i = boot_mode_e'(r3[31:30]);
    dbg_boot_mode_i = boot_mode_e'(r3[29:28]);
    dbg_boot_sel_i = r3[27];
    sd_cd_i = r3[26];
  endtask

  // Fan switches move every 48 cycles, so often mid-period
  task automatic run_random(input int cycles);
    logic [31:0] r;
    for (int i = 0; i < cycles; i++) begin
      drive_random();
      if (i % 48 == 0) begin
        case (fan_pick % 4)
          0:       fan_sw_i = 4'h0;
          1:       fan_sw_i = 4'hf;
          default: begin
            r = next_rand();
            fan_sw_i = r[31:28];
          end
        endcase
        fan_pick++;
      end
      @(posedge soc_clk);
      #1;
    end
  endtask

  task automatic wait_for_release(input int limit);
    int n;
    n = 0;
    while (!soc_rst_no && n < limit) begin
      @(posedge soc_clk);
      #1;
      n++;
    end
    if (!soc_rst_no) begin
      to_cnt++;
      $display("Timeout: SoC reset still active after %0d cycles", limit);
    end
  endtask

  task automatic wait_for_rtc_toggle(input int limit);
    logic prev;
    int n;
    prev = rtc_o;
    n = 0;
    while (rtc_o == prev && n < limit) begin
      @(posedge soc_clk);
      #1;
      n++;
    end
    if (rtc_o == prev) begin
      to_cnt++;
      $display("Timeout: RTC output did not toggle within %0d cycles", limit);
    end
  endtask

  initial begin
    rst_n = 1'b0;
    test_mode_i = 1'b0;
    dbg_reset_i = 1'b0;
    dbg_boot_sel_i = 1'b0;
    boot_mode_i = BOOT_SD;
    dbg_boot_mode_i = BOOT_PASSIVE;
    fan_sw_i = 4'h9;
    spi_i = '0;
    i2c_i = '0;
    usb_i = '0;
    sd_cd_i = 1'b0;
    {scl_tb_en, scl_tb, sda_tb_en, sda_tb, sd0_en, sd0_drv} = '0;
    {dp_tb_en, dp_tb, dm_tb_en, dm_tb} = '0;
    repeat (5) @(posedge soc_clk);
    #1;
    rst_n = 1'b1;
    wait_for_release(10);
    wait_for_rtc_toggle(60);
    run_random(400);

    // Debug reset with boot override
    dbg_boot_sel_i = 1'b1;
    dbg_boot_mode_i = BOOT_I2C_EEPROM;
    dbg_reset_i = 1'b1;
    repeat (3) @(posedge soc_clk);
    #1;
    dbg_reset_i = 1'b0;
    wait_for_release(10);
    run_random(300);

    // Test mode bypass
    test_mode_i = 1'b1;
    rst_n = 1'b0;
    @(posedge soc_clk);
    #1;
    rst_n = 1'b1;
    @(posedge soc_clk);
    #1;
    dbg_reset_i = 1'b1;
    @(posedge soc_clk);
    #1;
    dbg_reset_i = 1'b0;
    run_random(20);
    test_mode_i = 1'b0;
    run_random(200);
    wait_for_rtc_toggle(60);

    $display("Run complete: %0d errors, %0d timeouts", err_cnt, to_cnt);
    if (err_cnt == 0 && to_cnt == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// ==== board_shell.f ====
+incdir+.
board_shell_pkg.sv
sys_ctrl.sv
rtc_divider.sv
fan_ctrl.sv
pad_adapter.sv
board_shell.sv
tb_board_shell.sv
